// File: src.f
+incdir+hw
hw/rsa_pkg.sv
hw/mont_mul.sv
hw/mont_ladder.sv
hw/rsa_host_ctrl.sv
hw/rsa_top.sv
testbench/rsa_props.sv
testbench/rsa_checker.sv
testbench/tb_rsa.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rsa -f src.f -o tb_rsa_sim

out=$(./obj_dir/tb_rsa_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED"

// File: testbench/tb_rsa.sv
`default_nettype none
`include "rsa_cfg.svh"

module tb_rsa;

  localparam int W = `RSA_WIDTH;
  localparam int AW = `RSA_ADDR_WIDTH;
  localparam int N_RANDOM = 20;
  localparam int N_EDGE = 3;
  localparam int N_DELAY = 8;
  localparam int NUM_TESTS = N_RANDOM + N_EDGE + N_DELAY;
  localparam logic [31:0] SEED = 32'h11201117;
  localparam int CYCLE_LIMIT = NUM_TESTS * (W * 2 * (W + 4) + 200);

  logic                    clk;
  logic                    resetn;
  rsa_pkg::rsa_host_regs_t host_regs;
  rsa_pkg::rsa_status_t    status;
  rsa_pkg::rsa_dma_req_t   dma_req;
  rsa_pkg::rsa_dma_rsp_t   dma_rsp;

  logic          dma_done = 1'b0;
  logic          dma_idle = 1'b1;
  logic          dma_err;
  logic [W-1:0]  dma_data = '0;
  logic          dma_busy = 1'b0;
  logic [AW-1:0] dma_addr = '0;
  int            dma_wait = 0;
  int            next_wait;
  int            delay_q[$];
  logic [W-1:0]  mem [0:255];
  logic [7:0]    addr_tab [0:5];
  logic [31:0]   lfsr = SEED;
  int            cycles = 0;
  int            test_num;
  logic [1:0]    test_kind;
  int            tests_done;
  int            error_count;

  assign dma_rsp = '{done: dma_done, idle: dma_idle, error: dma_err, rx_data: dma_data};

  rsa_top dut0 (
    .clk       (clk),
    .resetn    (resetn),
    .host_regs (host_regs),
    .status    (status),
    .dma_req   (dma_req),
    .dma_rsp   (dma_rsp)
  );

  rsa_checker chk0 (
    .clk         (clk),
    .resetn      (resetn),
    .host_regs   (host_regs),
    .status      (status),
    .dma_req     (dma_req),
    .dma_rsp     (dma_rsp),
    .test_num    (test_num),
    .test_kind   (test_kind),
    .tests_done  (tests_done),
    .error_count (error_count)
  );

  bind rsa_host_ctrl rsa_props props0 (
    .clk     (clk),
    .resetn  (resetn),
    .dma_req (dma_req),
    .status  (status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[W-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic pick_addresses();
    logic [W-1:0] v;
    logic         clash;
    for (int i = 0; i < 6; i++) begin
      do begin
        draw_bits(8, v);
        clash = 1'b0;
        for (int j = 0; j < i; j++)
          if (addr_tab[j] == v[7:0]) clash = 1'b1;
      end while (clash);
      addr_tab[i] = v[7:0];
    end
  endtask

  // DMA engine model, one transfer at a time
  always @(posedge clk) begin
    if (!resetn) begin
      dma_busy <= 1'b0;
      dma_done <= 1'b0;
      dma_idle <= 1'b1;
      dma_wait <= 0;
    end else begin
      dma_done <= 1'b0;
      // Read data is only valid in the done cycle
      dma_data <= {dma_data[W-2:0], ~dma_data[W-1]};
      if (dma_req.rx_start || dma_req.tx_start) begin
        next_wait = 1;
        if (delay_q.size() > 0) next_wait = delay_q.pop_front();
        dma_busy <= 1'b1;
        dma_idle <= 1'b0;
        dma_addr <= dma_req.rx_start ? dma_req.rx_address : dma_req.tx_address;
        dma_wait <= next_wait;
      end else if (dma_busy) begin
        if (dma_wait <= 1) begin
          dma_busy <= 1'b0;
          dma_done <= 1'b1;
          dma_idle <= 1'b1;
          dma_data <= mem[dma_addr[7:0]];
        end else begin
          dma_wait <= dma_wait - 1;
        end
      end
    end
  end

  task automatic run_test(input int t);
    logic [W-1:0]   m, e, x, r, r2, v;
    logic [2*W-1:0] wide;
    logic [1:0]     kind;
    int             waited;
    int             hold;
    kind = (t < N_RANDOM) ? 2'd0 : (t < N_RANDOM + N_EDGE) ? 2'd1 : 2'd2;
    draw_bits(W, m);
    m[0] = 1'b1;
    if (m == W'(1)) m = W'(3);
    draw_bits(W, x);
    x = x % m;
    draw_bits(W, e);
    if (kind == 2'd1) e = (t == N_RANDOM) ? '0 : (t == N_RANDOM + 1) ? W'(1) : '1;
    // R = 2^W mod M, R2 = R * R mod M
    wide = '0;
    wide[W] = 1'b1;
    r = W'(wide % m);
    wide = {{W{1'b0}}, r} * {{W{1'b0}}, r};
    r2 = W'(wide % m);
    pick_addresses();
    mem[addr_tab[0]] = m;
    mem[addr_tab[1]] = e;
    mem[addr_tab[2]] = x;
    mem[addr_tab[3]] = r;
    mem[addr_tab[4]] = r2;
    for (int i = 0; i < 6; i++) begin
      if (kind == 2'd2) begin
        draw_bits(3, v);
        delay_q.push_back(int'(v[2:0]) + 1);
      end else begin
        delay_q.push_back(1);
      end
    end
    draw_bits(1, v);
    @(posedge clk);
    test_num <= t;
    test_kind <= kind;
    dma_err <= v[0];
    host_regs <= '{`RSA_CMD_COMPUTE, AW'(addr_tab[0]), AW'(addr_tab[1]), AW'(addr_tab[2]),
                   AW'(addr_tab[3]), AW'(addr_tab[4]), AW'(addr_tab[5])};
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited % 97 == 0) dma_err <= ~dma_err;
    end while (!status.done);
    draw_bits(3, v);
    hold = int'(v[2:0]) + 2;
    repeat (hold) @(posedge clk);
    host_regs.command <= `RSA_CMD_IDLE;
    do @(posedge clk); while (!status.idle);
    repeat (2) @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    resetn = 1'b0;
    host_regs = '0;
    dma_err = 1'b0;
    test_num = 0;
    test_kind = 2'd0;
    for (int i = 0; i < 256; i++) mem[i] = W'(32'h5a5a0000 ^ (i * 32'h01000193));
    repeat (10) @(posedge clk);
    resetn <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    repeat (5) @(posedge clk);
    $display("Tests finished %0d of %0d, errors %0d", tests_done, NUM_TESTS, error_count);
    if (error_count == 0 && tests_done == NUM_TESTS) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/rsa_checker.sv
`default_nettype none
`include "rsa_cfg.svh"

module rsa_checker (
  input  logic                    clk,
  input  logic                    resetn,
  input  rsa_pkg::rsa_host_regs_t host_regs,
  input  rsa_pkg::rsa_status_t    status,
  input  rsa_pkg::rsa_dma_req_t   dma_req,
  input  rsa_pkg::rsa_dma_rsp_t   dma_rsp,
  input  int                      test_num,
  input  logic [1:0]              test_kind,
  output int                      tests_done,
  output int                      error_count
);

  localparam int W  = `RSA_WIDTH;
  localparam int VW = (W > 32) ? W : 32;

  logic [W-1:0] ops [0:4];
  logic [W-1:0] expected;
  logic [W-1:0] got;
  int           rx_count = 0;
  int           test_errs = 0;
  int           n_tests = 0;
  int           n_errors = 0;
  logic         rx_pending = 1'b0;
  logic         tx_seen = 1'b0;
  logic         done_seen = 1'b0;
  logic         reset_checked = 1'b0;

  assign tests_done  = n_tests;
  assign error_count = n_errors;

  // Left-to-right square and multiply
  function automatic logic [W-1:0] mod_pow(input logic [W-1:0] x, e, m);
    logic [2*W-1:0] acc;
    acc = 1;
    for (int i = W - 1; i >= 0; i--) begin
      acc = (acc * acc) % m;
      if (e[i]) acc = (acc * x) % m;
    end
    return acc[W-1:0];
  endfunction

  function automatic string test_name(input int num, input logic [1:0] kind);
    case (kind)
      2'd0:    return $sformatf("random_%0d", num);
      2'd1:    return $sformatf("edge_%0d", num);
      default: return $sformatf("delay_%0d", num);
    endcase
  endfunction

  function automatic logic [31:0] exp_addr(input int idx);
    case (idx)
      0:       return host_regs.addr_m;
      1:       return host_regs.addr_e;
      2:       return host_regs.addr_x;
      3:       return host_regs.addr_r;
      default: return host_regs.addr_r2;
    endcase
  endfunction

  task automatic report_value(input string what, input logic [VW-1:0] exp, act);
    $display("Fail %s %s expected %h actual %h", test_name(test_num, test_kind),
             what, exp, act);
    test_errs++;
    n_errors++;
  endtask

  task automatic report_event(input string msg);
    $display("Error in %s: %s", test_name(test_num, test_kind), msg);
    test_errs++;
    n_errors++;
  endtask

  always @(posedge clk) begin
    if (resetn) begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (!status.idle || status.done || dma_req.rx_start || dma_req.tx_start)
          report_event("status or DMA starts wrong right after reset");
      end
      if (status.dma_error !== dma_rsp.error)
        report_value("dma_error", VW'(dma_rsp.error), VW'(status.dma_error));
      if (status.reserved !== '0)
        report_value("reserved", '0, VW'(status.reserved));

      if (dma_req.rx_start) begin
        if (done_seen) begin
          report_event("read started while done is held");
        end else if (rx_count >= 5) begin
          report_event("more than five reads in one operation");
        end else begin
          if (dma_req.rx_address !== exp_addr(rx_count))
            report_value("rx_address", VW'(exp_addr(rx_count)), VW'(dma_req.rx_address));
          rx_count++;
          rx_pending = 1'b1;
        end
      end else if (rx_pending && dma_rsp.done) begin
        ops[rx_count-1] = dma_rsp.rx_data;
        rx_pending = 1'b0;
      end

      if (dma_req.tx_start) begin
        if (rx_count != 5 || rx_pending)
          report_event("write started before all five operands were read");
        if (tx_seen)
          report_event("second write in one operation");
        if (dma_req.tx_address !== host_regs.addr_res)
          report_value("tx_address", VW'(host_regs.addr_res), VW'(dma_req.tx_address));
        // Operands arrive as M, E, X, R, R2
        expected = mod_pow(ops[2], ops[1], ops[0]);
        got = dma_req.tx_data;
        if (got !== expected) report_value("result", VW'(expected), VW'(got));
        tx_seen = 1'b1;
      end

      if (status.done && !done_seen) begin
        done_seen = 1'b1;
        if (!tx_seen) report_event("done rose before the result was written");
      end
      if (done_seen && !status.done && host_regs.command == `RSA_CMD_COMPUTE)
        report_event("done dropped while the command is still compute");

      if (done_seen && status.idle) begin
        if (test_errs == 0)
          $display("%s passed, result %h", test_name(test_num, test_kind), got);
        else
          $display("%s failed with %0d errors", test_name(test_num, test_kind), test_errs);
        n_tests++;
        rx_count = 0;
        test_errs = 0;
        tx_seen = 1'b0;
        done_seen = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/rsa_props.sv
`default_nettype none

module rsa_props (
  input logic                  clk,
  input logic                  resetn,
  input rsa_pkg::rsa_dma_req_t dma_req,
  input rsa_pkg::rsa_status_t  status
);

  a_start_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(dma_req.rx_start && dma_req.tx_start))
    else $error("rx_start and tx_start high in the same cycle");

  a_rx_pulse: assert property (@(posedge clk) disable iff (!resetn)
    dma_req.rx_start |=> !dma_req.rx_start)
    else $error("rx_start held longer than one cycle");

  a_tx_pulse: assert property (@(posedge clk) disable iff (!resetn)
    dma_req.tx_start |=> !dma_req.tx_start)
    else $error("tx_start held longer than one cycle");

  a_idle_done: assert property (@(posedge clk) disable iff (!resetn)
    !(status.idle && status.done))
    else $error("status idle and done high together");

  // A finished run must not fetch again
  a_no_rerun: assert property (@(posedge clk) disable iff (!resetn)
    status.done |-> !dma_req.rx_start)
    else $error("rx_start while status done is high");

endmodule

`default_nettype wire

// File: hw/rsa_top.sv
`default_nettype none
`include "rsa_cfg.svh"

module rsa_top (
  input  logic                  clk,
  input  logic                  resetn,
  input  rsa_pkg::rsa_host_regs_t host_regs,
  output rsa_pkg::rsa_status_t  status,
  output rsa_pkg::rsa_dma_req_t dma_req,
  input  rsa_pkg::rsa_dma_rsp_t dma_rsp
);

  rsa_pkg::rsa_operands_t operands;
  logic                   ladder_start;
  logic                   ladder_done;
  logic [`RSA_WIDTH-1:0]  ladder_result;

  logic                   mul_start;
  logic                   mul_done;
  logic [`RSA_WIDTH-1:0]  op_a;
  logic [`RSA_WIDTH-1:0]  op_b;
  logic [`RSA_WIDTH-1:0]  op_m;
  logic [`RSA_WIDTH-1:0]  mul_result;

  rsa_host_ctrl u_host (
    .clk           (clk),
    .resetn        (resetn),
    .host_regs     (host_regs),
    .dma_rsp       (dma_rsp),
    .dma_req       (dma_req),
    .status        (status),
    .operands      (operands),
    .ladder_start  (ladder_start),
    .ladder_done   (ladder_done),
    .ladder_result (ladder_result)
  );

  mont_ladder u_ladder (
    .clk        (clk),
    .resetn     (resetn),
    .start      (ladder_start),
    .operands   (operands),
    .result     (ladder_result),
    .done       (ladder_done),
    .mul_start  (mul_start),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_m       (op_m),
    .mul_done   (mul_done),
    .mul_result (mul_result)
  );

  mont_mul u_mul (
    .clk    (clk),
    .resetn (resetn),
    .start  (mul_start),
    .a      (op_a),
    .b      (op_b),
    .m      (op_m),
    .result (mul_result),
    .done   (mul_done)
  );

endmodule

`default_nettype wire

// File: hw/rsa_host_ctrl.sv
`default_nettype none
`include "rsa_cfg.svh"

module rsa_host_ctrl (
  input  logic                    clk,
  input  logic                    resetn,
  input  rsa_pkg::rsa_host_regs_t host_regs,
  input  rsa_pkg::rsa_dma_rsp_t   dma_rsp,
  output rsa_pkg::rsa_dma_req_t   dma_req,
  output rsa_pkg::rsa_status_t    status,
  output rsa_pkg::rsa_operands_t  operands,
  output logic                    ladder_start,
  input  logic                    ladder_done,
  input  logic [`RSA_WIDTH-1:0]   ladder_result
);

  localparam int SW = `RSA_HOST_STATE_W;

  localparam logic [SW-1:0] st_idle      = 3'd0;
  localparam logic [SW-1:0] st_rx        = 3'd1;
  localparam logic [SW-1:0] st_rx_wait   = 3'd2;
  localparam logic [SW-1:0] st_comp_wait = 3'd3;
  localparam logic [SW-1:0] st_tx        = 3'd4;
  localparam logic [SW-1:0] st_tx_wait   = 3'd5;
  localparam logic [SW-1:0] st_done      = 3'd6;

  logic [SW-1:0]               state;
  logic [2:0]                  idx;
  logic                        rx_start;
  logic                        tx_start;
  logic [`RSA_ADDR_WIDTH-1:0]  rx_address;
  logic [`RSA_ADDR_WIDTH-1:0]  next_addr;
  logic [`RSA_WIDTH-1:0]       res_reg;
  logic                        cmd_compute;
  logic                        cmd_idle;

  assign cmd_compute = (host_regs.command == `RSA_CMD_COMPUTE);
  assign cmd_idle    = (host_regs.command == `RSA_CMD_IDLE);

  // Operands are fetched in the order M, E, X, R, R2
  always_comb begin
    case (idx)
      3'd0:    next_addr = host_regs.addr_m;
      3'd1:    next_addr = host_regs.addr_e;
      3'd2:    next_addr = host_regs.addr_x;
      3'd3:    next_addr = host_regs.addr_r;
      default: next_addr = host_regs.addr_r2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= st_idle;
      idx          <= '0;
      rx_start     <= 1'b0;
      tx_start     <= 1'b0;
      ladder_start <= 1'b0;
    end else begin
      rx_start     <= 1'b0;
      tx_start     <= 1'b0;
      ladder_start <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_compute) begin
            idx   <= '0;
            state <= st_rx;
          end
        end
        st_rx: begin
          if (dma_rsp.idle) begin
            rx_start <= 1'b1;
            state    <= st_rx_wait;
          end
        end
        st_rx_wait: begin
          if (dma_rsp.done) begin
            if (idx == 3'd4) begin
              ladder_start <= 1'b1;
              state        <= st_comp_wait;
            end else begin
              idx   <= idx + 3'd1;
              state <= st_rx;
            end
          end
        end
        st_comp_wait: if (ladder_done) state <= st_tx;
        st_tx: begin
          if (dma_rsp.idle) begin
            tx_start <= 1'b1;
            state    <= st_tx_wait;
          end
        end
        st_tx_wait: if (dma_rsp.done) state <= st_done;
        // Hold here until the host drops the command, else it would rerun
        st_done: if (cmd_idle) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_rx && dma_rsp.idle) begin
      rx_address <= next_addr;
    end
    if (state == st_rx_wait && dma_rsp.done) begin
      case (idx)
        3'd0:    operands.m  <= dma_rsp.rx_data;
        3'd1:    operands.e  <= dma_rsp.rx_data;
        3'd2:    operands.x  <= dma_rsp.rx_data;
        3'd3:    operands.r  <= dma_rsp.rx_data;
        default: operands.r2 <= dma_rsp.rx_data;
      endcase
    end
    if (state == st_comp_wait && ladder_done) begin
      res_reg <= ladder_result;
    end
  end

  always_comb begin
    dma_req            = '0;
    dma_req.rx_start   = rx_start;
    dma_req.rx_address = rx_address;
    dma_req.tx_start   = tx_start;
    dma_req.tx_address = host_regs.addr_res;
    dma_req.tx_data    = res_reg;
  end

  always_comb begin
    status           = '0;
    status.dma_error = dma_rsp.error;
    status.idle      = (state == st_idle);
    status.done      = (state == st_done);
  end

endmodule

`default_nettype wire

// File: hw/mont_ladder.sv
`default_nettype none
`include "rsa_cfg.svh"

module mont_ladder (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   start,
  input  rsa_pkg::rsa_operands_t operands,
  output logic [`RSA_WIDTH-1:0]  result,
  output logic                   done,
  output logic                   mul_start,
  output logic [`RSA_WIDTH-1:0]  op_a,
  output logic [`RSA_WIDTH-1:0]  op_b,
  output logic [`RSA_WIDTH-1:0]  op_m,
  input  logic                   mul_done,
  input  logic [`RSA_WIDTH-1:0]  mul_result
);

  localparam int W  = `RSA_WIDTH;
  localparam int SW = `RSA_LADDER_STATE_W;

  localparam logic [SW-1:0] st_idle  = 3'd0;
  localparam logic [SW-1:0] st_setup = 3'd1;
  localparam logic [SW-1:0] st_op1   = 3'd2;
  localparam logic [SW-1:0] st_op2   = 3'd3;
  localparam logic [SW-1:0] st_final = 3'd4;

  logic [SW-1:0] state;
  logic [W-1:0]  a_reg;
  logic [W-1:0]  xx_reg;
  logic [W-1:0]  e_reg;
  logic [W-1:0]  step_cnt;
  logic          e_msb;
  logic          last_step;

  assign e_msb     = e_reg[W-1];
  assign last_step = (step_cnt == W'(W - 1));
  assign op_m      = operands.m;
  assign result    = a_reg;

  always_comb begin
    op_a = a_reg;
    op_b = xx_reg;
    case (state)
      // Map X into the Montgomery domain
      st_setup: begin
        op_a = operands.x;
        op_b = operands.r2;
      end
      // Square whichever register the exponent bit selects
      st_op2: begin
        op_a = e_msb ? xx_reg : a_reg;
        op_b = e_msb ? xx_reg : a_reg;
      end
      // Multiply by 1 to leave the Montgomery domain
      st_final: begin
        op_a = a_reg;
        op_b = W'(1);
      end
      default: begin
        op_a = a_reg;
        op_b = xx_reg;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= st_idle;
      mul_start <= 1'b0;
      done      <= 1'b0;
      step_cnt  <= '0;
    end else begin
      mul_start <= 1'b0;
      done      <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            step_cnt  <= '0;
            mul_start <= 1'b1;
            state     <= st_setup;
          end
        end
        st_setup: begin
          if (mul_done) begin
            mul_start <= 1'b1;
            state     <= st_op1;
          end
        end
        st_op1: begin
          if (mul_done) begin
            mul_start <= 1'b1;
            state     <= st_op2;
          end
        end
        st_op2: begin
          if (mul_done) begin
            mul_start <= 1'b1;
            step_cnt  <= step_cnt + 1'b1;
            state     <= last_step ? st_final : st_op1;
          end
        end
        st_final: begin
          if (mul_done) begin
            done  <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (start) begin
          a_reg <= operands.r;
          e_reg <= operands.e;
        end
      end
      st_setup: if (mul_done) xx_reg <= mul_result;
      st_op1: begin
        if (mul_done) begin
          if (e_msb) a_reg <= mul_result;
          else xx_reg <= mul_result;
        end
      end
      st_op2: begin
        if (mul_done) begin
          if (e_msb) xx_reg <= mul_result;
          else a_reg <= mul_result;
          e_reg <= e_reg << 1;
        end
      end
      st_final: if (mul_done) a_reg <= mul_result;
      default: a_reg <= a_reg;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mont_mul.sv
`default_nettype none
`include "rsa_cfg.svh"

module mont_mul (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  start,
  input  logic [`RSA_WIDTH-1:0] a,
  input  logic [`RSA_WIDTH-1:0] b,
  input  logic [`RSA_WIDTH-1:0] m,
  output logic [`RSA_WIDTH-1:0] result,
  output logic                  done
);

  localparam int W  = `RSA_WIDTH;
  localparam int CW = $clog2(W) + 1;

  logic [W-1:0]  a_sh;
  logic [W-1:0]  b_r;
  logic [W-1:0]  m_r;
  logic [W:0]    acc;
  logic [W:0]    acc_next;
  logic [W-1:0]  acc_sub;
  logic [W+1:0]  sum_b;
  logic [W+1:0]  sum_m;
  logic [CW-1:0] cnt;
  logic          busy;
  logic          last;

  // One radix-2 step; accumulator stays below 2m
  assign sum_b    = {1'b0, acc} + (a_sh[0] ? {2'b00, b_r} : '0);
  assign sum_m    = sum_b + (sum_b[0] ? {2'b00, m_r} : '0);
  assign acc_next = sum_m[W+1:1];
  assign acc_sub  = acc_next[W-1:0] - m_r;
  assign last     = (cnt == CW'(W - 1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      a_sh <= a;
      b_r  <= b;
      m_r  <= m;
      acc  <= '0;
    end else if (busy) begin
      a_sh <= a_sh >> 1;
      acc  <= acc_next;
      // Final subtraction folded into the last step
      if (last) begin
        result <= (acc_next >= {1'b0, m_r}) ? acc_sub : acc_next[W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rsa_pkg.sv
`default_nettype none
`include "rsa_cfg.svh"

package rsa_pkg;

  typedef struct packed {
    logic [31:0]                command;
    logic [`RSA_ADDR_WIDTH-1:0] addr_m;
    logic [`RSA_ADDR_WIDTH-1:0] addr_e;
    logic [`RSA_ADDR_WIDTH-1:0] addr_x;
    logic [`RSA_ADDR_WIDTH-1:0] addr_r;
    logic [`RSA_ADDR_WIDTH-1:0] addr_r2;
    logic [`RSA_ADDR_WIDTH-1:0] addr_res;
  } rsa_host_regs_t;

  typedef struct packed {
    logic [28:0] reserved;
    logic        dma_error;
    logic        idle;
    logic        done;
  } rsa_status_t;

  typedef struct packed {
    logic                       rx_start;
    logic [`RSA_ADDR_WIDTH-1:0] rx_address;
    logic                       tx_start;
    logic [`RSA_ADDR_WIDTH-1:0] tx_address;
    logic [`RSA_WIDTH-1:0]      tx_data;
  } rsa_dma_req_t;

  typedef struct packed {
    logic                  done;
    logic                  idle;
    logic                  error;
    logic [`RSA_WIDTH-1:0] rx_data;
  } rsa_dma_rsp_t;

  // Captured operands, all in the same W-bit width
  typedef struct packed {
    logic [`RSA_WIDTH-1:0] m;
    logic [`RSA_WIDTH-1:0] e;
    logic [`RSA_WIDTH-1:0] x;
    logic [`RSA_WIDTH-1:0] r;
    logic [`RSA_WIDTH-1:0] r2;
  } rsa_operands_t;

endpackage

`default_nettype wire

// File: hw/rsa_cfg.svh
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// Operand width in bits
`define RSA_WIDTH 32
`define RSA_ADDR_WIDTH 32

// Host command codes
`define RSA_CMD_IDLE 32'd0
`define RSA_CMD_COMPUTE 32'd1

// FSM state register widths
`define RSA_HOST_STATE_W 3
`define RSA_LADDER_STATE_W 3

`endif
